//--- project.f
+incdir+verification
rtl/rowsum_pkg.sv
rtl/rowsum_ctrl_if.sv
rtl/rowsum_controller.sv
rtl/rowsum_counters.sv
rtl/rowsum_accumulator.sv
rtl/rowsum_stage.sv
verification/rowsum_stage_tb.sv

//--- rtl/rowsum_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module rowsum_accumulator (
    input  wire logic               clk,
    input  wire logic               rst,
    rowsum_ctrl_if.acc              acc,
    input  wire rowsum_pkg::pixel_t pix_data,
    input  wire rowsum_pkg::col_t   col,
    input  wire logic               sum_strobe,
    output logic                    sum_valid,
    output rowsum_pkg::col_t        sum_col,
    output rowsum_pkg::sum_t        sum_data
);

    rowsum_pkg::sum_t run_sum;
    rowsum_pkg::sum_t pix_ext;
    rowsum_pkg::sum_t sum_next;

    assign pix_ext  = rowsum_pkg::sum_t'(pix_data);
    // prefix sum including the pixel on the bus this cycle
    assign sum_next = run_sum + pix_ext;

    // first pixel of a row replaces the old total
    always_ff @(posedge clk) begin
        if (acc.ld_en) begin
            run_sum <= pix_ext;
        end else if (acc.sum_en || acc.cum_en) begin
            run_sum <= sum_next;
        end
    end

    // result register, column tagged with the sum it closes
    always_ff @(posedge clk) begin
        if (sum_strobe) begin
            sum_data <= sum_next;
            sum_col  <= col;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= sum_strobe;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rowsum_controller.sv
`timescale 1ns/1ps
`default_nettype none

module rowsum_controller #(
    parameter int COLS   = 16,
    parameter int WARMUP = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              frame_valid,
    input  wire logic              start_gt_2,
    input  wire rowsum_pkg::col_t  col,
    input  wire logic              row_eq_max,
    rowsum_ctrl_if.ctrl            ctrl,
    output logic                   sum_strobe,
    output logic                   frame_done
);

    rowsum_pkg::ctrl_state_t state;
    rowsum_pkg::ctrl_state_t next_state;

    // frame ends early on loss of upstream, or normally after the last row
    logic abort;
    // column where warm-up ends, so CUM_EN starts at column WARMUP
    logic warm_done;
    logic row_end;

    assign abort     = !frame_valid || row_eq_max;
    assign warm_done = (col >= rowsum_pkg::col_t'(WARMUP - 1));
    assign row_end   = (col >= rowsum_pkg::col_t'(COLS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rowsum_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rowsum_pkg::IDLE: begin
                if (frame_valid) begin
                    next_state = rowsum_pkg::START;
                end
            end
            rowsum_pkg::START: begin
                if (abort) begin
                    next_state = rowsum_pkg::FINISH_ALL;
                end else if (start_gt_2) begin
                    next_state = rowsum_pkg::START_ROW;
                end
            end
            rowsum_pkg::START_ROW: begin
                if (abort) begin
                    next_state = rowsum_pkg::FINISH_ALL;
                end else begin
                    next_state = rowsum_pkg::SUM_EN;
                end
            end
            rowsum_pkg::SUM_EN: begin
                if (abort) begin
                    next_state = rowsum_pkg::FINISH_ALL;
                end else if (warm_done) begin
                    next_state = rowsum_pkg::CUM_EN;
                end
            end
            rowsum_pkg::CUM_EN: begin
                if (abort) begin
                    next_state = rowsum_pkg::FINISH_ALL;
                end else if (row_end) begin
                    next_state = rowsum_pkg::START_ROW;
                end
            end
            rowsum_pkg::FINISH_ALL: begin
                next_state = rowsum_pkg::DONE;
            end
            // no restart, held until reset
            rowsum_pkg::DONE: begin
                next_state = rowsum_pkg::DONE;
            end
            default: begin
                next_state = rowsum_pkg::IDLE;
            end
        endcase
    end

    // moore outputs, every strobe decoded from the state alone
    always_comb begin
        ctrl.start_en = (state == rowsum_pkg::START);
        ctrl.ld_en    = (state == rowsum_pkg::START_ROW);
        ctrl.sum_en   = (state == rowsum_pkg::SUM_EN);
        ctrl.cum_en   = (state == rowsum_pkg::CUM_EN);
        ctrl.count_en = (state == rowsum_pkg::START_ROW) ||
                        (state == rowsum_pkg::SUM_EN) ||
                        (state == rowsum_pkg::CUM_EN);
        sum_strobe    = (state == rowsum_pkg::CUM_EN);
        frame_done    = (state == rowsum_pkg::FINISH_ALL);
    end

endmodule

`default_nettype wire

//--- rtl/rowsum_counters.sv
`timescale 1ns/1ps
`default_nettype none

module rowsum_counters #(
    parameter int COLS = 16,
    parameter int ROWS = 4
) (
    input  wire logic         clk,
    input  wire logic         rst,
    rowsum_ctrl_if.cnt        ctrl,
    output logic              start_gt_2,
    output rowsum_pkg::col_t  col,
    output rowsum_pkg::row_t  row_idx,
    output logic              row_eq_max
);

    logic [1:0]        settle_cnt;
    rowsum_pkg::col_t  col_q;
    // rows started so far
    rowsum_pkg::row_t  row_cnt;
    logic              last_col;
    logic              row_eq_max_q;

    // settle delay, restarts whenever START is left
    always_ff @(posedge clk) begin
        if (rst) begin
            settle_cnt <= '0;
        end else if (ctrl.start_en) begin
            settle_cnt <= settle_cnt + 2'd1;
        end else begin
            settle_cnt <= '0;
        end
    end

    assign start_gt_2 = (settle_cnt > 2'd2);

    assign last_col = (col_q == rowsum_pkg::col_t'(COLS - 1));

    // the counter holds the column being addressed in this cycle.
    // it wraps to 0 on the last column so START_ROW already reads column 0
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
        end else if (ctrl.count_en) begin
            if (last_col) begin
                col_q <= '0;
            end else begin
                col_q <= col_q + rowsum_pkg::col_t'(1);
            end
        end
    end

    assign col = col_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            row_cnt <= '0;
        end else if (ctrl.ld_en) begin
            row_cnt <= row_cnt + rowsum_pkg::row_t'(1);
        end
    end

    // START_ROW still shows the row about to start, later cycles the started one
    always_comb begin
        if (ctrl.ld_en || row_cnt == '0) begin
            row_idx = row_cnt;
        end else begin
            row_idx = row_cnt - rowsum_pkg::row_t'(1);
        end
    end

    // sticky, set as the final row's last column goes by
    always_ff @(posedge clk) begin
        if (rst) begin
            row_eq_max_q <= 1'b0;
        end else if (ctrl.count_en && last_col &&
                     row_cnt == rowsum_pkg::row_t'(ROWS)) begin
            row_eq_max_q <= 1'b1;
        end
    end

    assign row_eq_max = row_eq_max_q;

endmodule

`default_nettype wire

//--- rtl/rowsum_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rowsum_ctrl_if;

    // settle delay running
    logic start_en;
    // first column of a row
    logic ld_en;
    // column counter advance
    logic count_en;
    // warm-up accumulation, no output
    logic sum_en;
    // accumulation with output
    logic cum_en;

    modport ctrl (
        output start_en,
        output ld_en,
        output count_en,
        output sum_en,
        output cum_en
    );

    modport cnt (
        input start_en,
        input ld_en,
        input count_en
    );

    modport acc (
        input ld_en,
        input sum_en,
        input cum_en
    );

endinterface

`default_nettype wire

//--- rtl/rowsum_pkg.sv
`default_nettype none

package rowsum_pkg;

    // one pixel from the frame buffer
    typedef logic [7:0] pixel_t;

    // prefix sum, wide enough for 1023 pixels of 255
    typedef logic [17:0] sum_t;

    // column index, doubles as the frame buffer read address
    typedef logic [9:0] col_t;

    // row count within a frame
    typedef logic [9:0] row_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        START,
        START_ROW,
        SUM_EN,
        CUM_EN,
        FINISH_ALL,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/rowsum_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rowsum_stage #(
    parameter int COLS   = 16,
    parameter int ROWS   = 4,
    parameter int WARMUP = 4
) (
    input  wire logic               clk,
    input  wire logic               rst,
    // upstream frame present
    input  wire logic               frame_valid,
    // combinational read data for pix_addr in row row_idx
    input  wire rowsum_pkg::pixel_t pix_data,
    output rowsum_pkg::col_t        pix_addr,
    output rowsum_pkg::row_t        row_idx,
    output logic                    sum_valid,
    output rowsum_pkg::col_t        sum_col,
    output rowsum_pkg::sum_t        sum_data,
    output logic                    frame_done
);

    rowsum_ctrl_if ctrl_bus ();

    logic              start_gt_2;
    logic              row_eq_max;
    logic              sum_strobe;
    rowsum_pkg::col_t  col;

    rowsum_controller #(
        .COLS   (COLS),
        .WARMUP (WARMUP)
    ) rowsum_controller_i (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .start_gt_2  (start_gt_2),
        .col         (col),
        .row_eq_max  (row_eq_max),
        .ctrl        (ctrl_bus.ctrl),
        .sum_strobe  (sum_strobe),
        .frame_done  (frame_done)
    );

    rowsum_counters #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) rowsum_counters_i (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl_bus.cnt),
        .start_gt_2 (start_gt_2),
        .col        (col),
        .row_idx    (row_idx),
        .row_eq_max (row_eq_max)
    );

    rowsum_accumulator rowsum_accumulator_i (
        .clk        (clk),
        .rst        (rst),
        .acc        (ctrl_bus.acc),
        .pix_data   (pix_data),
        .col        (col),
        .sum_strobe (sum_strobe),
        .sum_valid  (sum_valid),
        .sum_col    (sum_col),
        .sum_data   (sum_data)
    );

    // column index is the read address
    assign pix_addr = col;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the rowsum_stage testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module rowsum_stage_tb \
    -Mdir obj_dir -o rowsum_stage_tb > build.log 2>&1 \
    && ./obj_dir/rowsum_stage_tb > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "TEST OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- verification/rowsum_vectors.svh
`ifndef ROWSUM_VECTORS_SVH
`define ROWSUM_VECTORS_SVH

`default_nettype none

// fill modes of the frame buffer model
localparam int FILL_RANDOM = 0;
localparam int FILL_MAX    = 1;
localparam int FILL_RAMP   = 2;

// frame_valid stays high for the whole frame
localparam int NO_DROP = -1;
// sum_valid pulses seen in the drop row before frame_valid goes low
localparam int DROP_AFTER = 2;

localparam int NUM_VECTORS = 6;

typedef struct packed {
    int fill;
    int drop_row;
    int exp_outputs;
} vector_t;

// columns: fill mode, row in which frame_valid drops, sum_valid pulses expected.
// full frame is 4 rows of 12 sums; a drop gives the finished rows,
// DROP_AFTER sums and the one sum still in flight
localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{FILL_RANDOM, NO_DROP, 48},
    '{FILL_MAX,    NO_DROP, 48},
    '{FILL_RAMP,   NO_DROP, 48},
    '{FILL_RANDOM, 1,       15},
    '{FILL_RAMP,   0,       3},
    '{FILL_MAX,    3,       39}
};

function automatic string vector_name(input int idx);
    case (idx)
        0: return "random_full";
        1: return "max_full";
        2: return "ramp_full";
        3: return "random_drop_row1";
        4: return "ramp_drop_row0";
        5: return "max_drop_row3";
        default: return "unknown";
    endcase
endfunction

`default_nettype wire

`endif

//--- verification/rowsum_stage_tb.sv
`timescale 1ns/1ps
`include "rowsum_vectors.svh"
`default_nettype none

module rowsum_stage_tb;

    localparam int COLS        = 16;
    localparam int ROWS        = 4;
    localparam int WARMUP      = 4;
    localparam int PER_ROW     = COLS - WARMUP;
    localparam int CLK_PERIOD  = 20;
    localparam int IDLE_CYCLES = 5;
    localparam int TAIL_CYCLES = 8;
    // one frame plus reset, idle and tail margin
    localparam int CYCLES_PER_VECTOR = ROWS * (COLS + 4) + 20;

    logic               clk;
    logic               rst;
    logic               frame_valid;
    rowsum_pkg::pixel_t pix_data;
    rowsum_pkg::col_t   pix_addr;
    rowsum_pkg::row_t   row_idx;
    logic               sum_valid;
    rowsum_pkg::col_t   sum_col;
    rowsum_pkg::sum_t   sum_data;
    logic               frame_done;

    // row major frame buffer model
    rowsum_pkg::pixel_t fb [ROWS * COLS];
    int seed;
    int errors;
    int tests_failed;

    rowsum_stage #(
        .COLS   (COLS),
        .ROWS   (ROWS),
        .WARMUP (WARMUP)
    ) rowsum_stage_i (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .pix_data    (pix_data),
        .pix_addr    (pix_addr),
        .row_idx     (row_idx),
        .sum_valid   (sum_valid),
        .sum_col     (sum_col),
        .sum_data    (sum_data),
        .frame_done  (frame_done)
    );

    // combinational read with rows past the frame reading as zero
    always_comb begin
        if (int'(row_idx) < ROWS && int'(pix_addr) < COLS) begin
            pix_data = fb[int'(row_idx) * COLS + int'(pix_addr)];
        end else begin
            pix_data = '0;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (NUM_VECTORS * CYCLES_PER_VECTOR) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 NUM_VECTORS * CYCLES_PER_VECTOR);
        $display("TEST FAILED");
        $finish;
    end

    // prefix sum of one row over columns 0 through col
    function automatic int expected_sum(input int row, input int col);
        int total;
        total = 0;
        for (int c = 0; c <= col; c++) begin
            total += int'(fb[row * COLS + c]);
        end
        return total;
    endfunction

    task automatic fill_frame(input int mode);
        int addr;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                addr = r * COLS + c;
                case (mode)
                    FILL_MAX:  fb[addr] = 8'hff;
                    FILL_RAMP: fb[addr] = rowsum_pkg::pixel_t'(addr * 4 + 1);
                    default:   fb[addr] = rowsum_pkg::pixel_t'($random(seed));
                endcase
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        frame_valid = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic check_quiet(input string name, input string phase);
        if (sum_valid !== 1'b0) begin
            $display("%s: sum_valid high %s", name, phase);
            errors++;
        end
        if (frame_done !== 1'b0) begin
            $display("%s: frame_done high %s", name, phase);
            errors++;
        end
    endtask

    task automatic run_vector(input int idx);
        string   name;
        vector_t vec;
        int      start_errors;
        int      out_count;
        int      exp_row;
        int      exp_col;
        int      exp_sum;
        bit      done_seen;
        bit      dropped;
        name = vector_name(idx);
        vec = VECTORS[idx];
        start_errors = errors;
        out_count = 0;
        done_seen = 1'b0;
        dropped = 1'b0;
        apply_reset();
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_quiet(name, "while idle after reset");
        end
        fill_frame(vec.fill);
        frame_valid = 1'b1;
        while (!done_seen) begin
            @(negedge clk);
            if (sum_valid === 1'b1) begin
                // outputs arrive in row order with WARMUP..COLS-1 in each row
                exp_row = out_count / PER_ROW;
                exp_col = WARMUP + out_count % PER_ROW;
                if (out_count >= vec.exp_outputs) begin
                    $display("%s: more sum_valid pulses than the %0d expected",
                             name, vec.exp_outputs);
                    errors++;
                end else begin
                    if (sum_col !== rowsum_pkg::col_t'(exp_col)) begin
                        $display("Fail %s sum_col: expected %0d, actual %0d",
                                 name, exp_col, sum_col);
                        errors++;
                    end
                    exp_sum = expected_sum(exp_row, exp_col);
                    if (sum_data !== rowsum_pkg::sum_t'(exp_sum)) begin
                        $display("Fail %s sum_data row %0d col %0d: expected %0d, actual %0d",
                                 name, exp_row, exp_col, exp_sum, sum_data);
                        errors++;
                    end
                end
                out_count++;
                if (vec.drop_row != NO_DROP && !dropped &&
                    out_count == vec.drop_row * PER_ROW + DROP_AFTER) begin
                    frame_valid = 1'b0;
                    dropped = 1'b1;
                end
            end
            if (frame_done === 1'b1) begin
                done_seen = 1'b1;
                if (out_count != vec.exp_outputs) begin
                    $display("Fail %s outputs at frame_done: expected %0d, actual %0d",
                             name, vec.exp_outputs, out_count);
                    errors++;
                end
                // a full frame ends one cycle after its last sum
                if (vec.drop_row == NO_DROP && sum_valid === 1'b1) begin
                    $display("%s: frame_done came together with a sum, not after the last one",
                             name);
                    errors++;
                end
            end
        end
        // stage stays done and nothing more may come out
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            check_quiet(name, "after frame_done");
        end
        frame_valid = 1'b0;
        if (errors == start_errors) begin
            $display("%s: passed, %0d sums checked", name, out_count);
        end else begin
            $display("%s: failed with %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    initial begin
        rst = 1'b1;
        frame_valid = 1'b0;
        seed = 45;
        errors = 0;
        tests_failed = 0;
        for (int i = 0; i < ROWS * COLS; i++) begin
            fb[i] = '0;
        end
        for (int v = 0; v < NUM_VECTORS; v++) begin
            run_vector(v);
        end
        $display("vectors run %0d, failed %0d, errors %0d",
                 NUM_VECTORS, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
